// File: dcache_miss_pkg.sv
/*
 * L1 data cache miss controller, shared definitions.
 * Address geometry, the two decodings of an address word
 * and the refill state encoding.
 */

`default_nettype none

package dcache_miss_pkg;

    // address geometry
    localparam int ADDR_W    = 32;
    localparam int BYTE_SEL  = 2;
    localparam int WORD_SEL  = 4;
    localparam int ENTRY_SEL = 7;
    localparam int TAG_W     = ADDR_W - ENTRY_SEL - WORD_SEL - BYTE_SEL;
    localparam int VC_TAG_W  = TAG_W + ENTRY_SEL;
    localparam int LINE_W    = ADDR_W - WORD_SEL - BYTE_SEL;

    // store path and set shape
    localparam int DATA_W  = 32;
    localparam int STRB_W  = 4;
    localparam int L1_WAYS = 2;

    // L1 view of an address
    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        logic [ENTRY_SEL-1:0] entry;
        logic [WORD_SEL-1:0]  word;
        logic [BYTE_SEL-1:0]  byte_off;
    } l1_addr_t;

    // victim cache view, fully associative so tag covers the set index
    typedef struct packed {
        logic [VC_TAG_W-1:0]  vc_tag;
        logic [WORD_SEL-1:0]  word;
        logic [BYTE_SEL-1:0]  byte_off;
    } vc_addr_t;

    typedef union packed {
        l1_addr_t l1;
        vc_addr_t vc;
    } dcache_addr_u;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        DRAIN  = 3'd1,
        FETCH  = 3'd2,
        VICTIM = 3'd3,
        FILL   = 3'd4
    } refill_state_e;

endpackage

`default_nettype wire

// File: refill_if.sv
/*
 * Refill control bundle.
 * Links the refill FSM, the victim record and the L2 port mux:
 * state flags from the FSM, the captured line from the record
 * and the read completion from the port mux.
 */

`timescale 1ns/10ps
`default_nettype none

interface refill_if;

    // from the FSM
    logic capture;
    logic busy;
    logic fetch;

    // from the victim record
    logic                              all_occupied;
    logic [dcache_miss_pkg::LINE_W-1:0] line_addr;

    // from the port mux
    logic rd_resp;

    modport fsm (
        output capture, busy, fetch,
        input  all_occupied, rd_resp
    );

    modport rec (
        input  capture,
        output all_occupied, line_addr
    );

    modport port (
        input  busy, fetch, line_addr,
        output rd_resp
    );

endinterface

`default_nettype wire

// File: refill_fsm.sv
/*
 * Refill FSM.
 * Accepts a missed load, drains outstanding stores, fetches the
 * line from L2, writes the victim tag and finishes with the tag
 * write of the refill way.
 */

`timescale 1ns/10ps
`default_nettype none

module refill_fsm (
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    input  wire logic  ld_valid_i,
    input  wire logic  credits_zero_i,
    output logic       ld_ready_o,
    output logic       vc_wr_en_o,
    output logic       refill_wr_en_o,
    output logic       ld_refill_done_o,
    refill_if.fsm      rif
);

    dcache_miss_pkg::refill_state_e state_q;
    dcache_miss_pkg::refill_state_e state_d;

    logic ld_accept;

    // ******************************************************************
    // state register and next state
    // ******************************************************************
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= dcache_miss_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            dcache_miss_pkg::IDLE: begin
                if (ld_accept) begin
                    state_d = dcache_miss_pkg::DRAIN;
                end
            end
            dcache_miss_pkg::DRAIN: begin
                // every store ahead of the read must be acknowledged
                if (credits_zero_i) begin
                    state_d = dcache_miss_pkg::FETCH;
                end
            end
            dcache_miss_pkg::FETCH: begin
                if (rif.rd_resp) begin
                    state_d = dcache_miss_pkg::VICTIM;
                end
            end
            dcache_miss_pkg::VICTIM: begin
                state_d = dcache_miss_pkg::FILL;
            end
            dcache_miss_pkg::FILL: begin
                state_d = dcache_miss_pkg::IDLE;
            end
            default: begin
                state_d = dcache_miss_pkg::IDLE;
            end
        endcase
    end

    // ******************************************************************
    // outputs decoded from state
    // ******************************************************************
    assign ld_ready_o = (state_q == dcache_miss_pkg::IDLE);
    assign ld_accept  = ld_valid_i && ld_ready_o;

    assign rif.capture = ld_accept;
    assign rif.busy    = (state_q != dcache_miss_pkg::IDLE);
    assign rif.fetch   = (state_q == dcache_miss_pkg::FETCH);

    // victim only written back when the set had no free way
    assign vc_wr_en_o = (state_q == dcache_miss_pkg::VICTIM) && rif.all_occupied;

    assign refill_wr_en_o   = (state_q == dcache_miss_pkg::FILL);
    assign ld_refill_done_o = (state_q == dcache_miss_pkg::FILL);

endmodule

`default_nettype wire

// File: store_credit_counter.sv
/*
 * Outstanding store counter.
 * Counts stores written through to L2 that have not been
 * acknowledged yet, and flags the empty and full levels.
 */

`timescale 1ns/10ps
`default_nettype none

module store_credit_counter #(
    parameter int STORE_CNT_W = 2
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic store_issue_i,
    input  wire logic store_retire_i,
    output logic      credits_zero_o,
    output logic      credits_full_o
);

    logic [STORE_CNT_W-1:0] count_q;

    // issue and retire in one cycle cancel out
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (store_issue_i && !store_retire_i) begin
            count_q <= count_q + STORE_CNT_W'(1);
        end else if (store_retire_i && !store_issue_i) begin
            count_q <= count_q - STORE_CNT_W'(1);
        end
    end

    assign credits_zero_o = ~|count_q;

    // all ones is the last usable level
    assign credits_full_o = &count_q;

endmodule

`default_nettype wire

// File: victim_record.sv
/*
 * Victim record.
 * Holds the missed load address and the set snapshot taken at
 * load acceptance, and forms the line address, the refill way and
 * entry, and the victim cache tag of the LRU way.
 */

`timescale 1ns/10ps
`default_nettype none

module victim_record (
    input  wire logic                                clk_i,
    input  wire logic                                rst_n_i,
    input  wire logic [dcache_miss_pkg::ADDR_W-1:0]  ld_addr_i,
    input  wire logic [dcache_miss_pkg::L1_WAYS-1:0] way_valid_i,
    input  wire logic [dcache_miss_pkg::L1_WAYS-1:0][dcache_miss_pkg::TAG_W-1:0] way_tag_i,
    input  wire logic [dcache_miss_pkg::L1_WAYS-1:0] lru_onehot_i,
    output logic [dcache_miss_pkg::VC_TAG_W-1:0]     vc_tag_o,
    output logic [dcache_miss_pkg::L1_WAYS-1:0]      refill_way_o,
    output logic [dcache_miss_pkg::ENTRY_SEL-1:0]    refill_entry_o,
    refill_if.rec                                    rif
);

    dcache_miss_pkg::dcache_addr_u                                        addr_q;
    logic [dcache_miss_pkg::L1_WAYS-1:0][dcache_miss_pkg::TAG_W-1:0]      way_tag_q;
    logic [dcache_miss_pkg::L1_WAYS-1:0]                                  way_valid_q;
    logic [dcache_miss_pkg::L1_WAYS-1:0]                                  lru_q;
    logic [dcache_miss_pkg::TAG_W-1:0]                                    lru_tag;
    dcache_miss_pkg::dcache_addr_u                                        victim_addr;

    // occupancy and LRU way of the missed set
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            way_valid_q <= '0;
            lru_q       <= '0;
        end else if (rif.capture) begin
            way_valid_q <= way_valid_i;
            lru_q       <= lru_onehot_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rif.capture) begin
            addr_q    <= ld_addr_i;
            way_tag_q <= way_tag_i;
        end
    end

    // tag of the way to be replaced
    always_comb begin
        lru_tag = '0;
        for (int w = 0; w < dcache_miss_pkg::L1_WAYS; w++) begin
            if (lru_q[w]) begin
                lru_tag = lru_tag | way_tag_q[w];
            end
        end
    end

    // rebuild the victim line in L1 terms, read it back as a vc tag
    always_comb begin
        victim_addr.l1.tag      = lru_tag;
        victim_addr.l1.entry    = addr_q.l1.entry;
        victim_addr.l1.word     = '0;
        victim_addr.l1.byte_off = '0;
    end

    assign vc_tag_o         = victim_addr.vc.vc_tag;
    assign rif.line_addr    = addr_q.vc.vc_tag;
    assign rif.all_occupied = &way_valid_q;
    assign refill_way_o     = lru_q;
    assign refill_entry_o   = addr_q.l1.entry;

endmodule

`default_nettype wire

// File: l2_port_mux.sv
/*
 * L2 port mux.
 * Admits write-through stores, muxes the refill read and the
 * store write onto the single L2 request port and routes each
 * in-order response to store retirement or read completion.
 */

`timescale 1ns/10ps
`default_nettype none

module l2_port_mux #(
    parameter int STORE_CNT_W = 2
) (
    input  wire logic [dcache_miss_pkg::ADDR_W-1:0] st_addr_i,
    input  wire logic [dcache_miss_pkg::DATA_W-1:0] st_wdata_i,
    input  wire logic [dcache_miss_pkg::STRB_W-1:0] st_strb_i,
    input  wire logic                               st_valid_i,
    input  wire logic                               l2_resp_i,
    input  wire logic                               credits_zero_i,
    input  wire logic                               credits_full_i,
    output logic                                    st_ready_o,
    output logic                                    st_ack_o,
    output logic                                    store_issue_o,
    output logic                                    store_retire_o,
    output logic                                    l2_rd_en_o,
    output logic                                    l2_wr_en_o,
    output logic [dcache_miss_pkg::ADDR_W-1:0]      l2_addr_o,
    output logic [dcache_miss_pkg::DATA_W-1:0]      l2_wdata_o,
    output logic [dcache_miss_pkg::STRB_W-1:0]      l2_wstrb_o,
    refill_if.port                                  rif
);

    localparam int OFFSET_W = dcache_miss_pkg::ADDR_W - dcache_miss_pkg::LINE_W;

    dcache_miss_pkg::dcache_addr_u st_addr_u;
    logic                          line_conflict;
    logic                          st_accept;

    // counter needs at least one bit
    if (STORE_CNT_W < 1) begin : g_cnt_width_check
        $error("l2_port_mux: STORE_CNT_W must be at least 1");
    end

    // ******************************************************************
    // store admission
    // ******************************************************************
    assign st_addr_u = st_addr_i;

    // same line as the refill in progress would race the fill
    assign line_conflict = rif.busy && (st_addr_u.vc.vc_tag == rif.line_addr);

    assign st_ready_o    = !(line_conflict || rif.fetch || credits_full_i);
    assign st_accept     = st_valid_i && st_ready_o;
    assign store_issue_o = st_accept;

    // ******************************************************************
    // request mux, read wins only while fetching
    // ******************************************************************
    assign l2_rd_en_o = rif.fetch;
    assign l2_wr_en_o = st_accept;
    assign l2_addr_o  = rif.fetch ? {rif.line_addr, {OFFSET_W{1'b0}}} : st_addr_i;
    assign l2_wdata_o = st_wdata_i;
    assign l2_wstrb_o = st_strb_i;

    // ******************************************************************
    // response routing
    // ******************************************************************
    // L2 answers in order, so pending stores take the response first
    assign st_ack_o       = l2_resp_i && !credits_zero_i;
    assign store_retire_o = st_ack_o;
    assign rif.rd_resp    = l2_resp_i && credits_zero_i && rif.fetch;

endmodule

`default_nettype wire

// File: dcache_miss_ctrl.sv
/*
 * L1 data cache miss and write-through controller.
 * Sits between the load/store unit and L2: refills missed lines,
 * records victims for the victim cache and passes stores through
 * to L2 while tracking their acknowledgements.
 */

`timescale 1ns/10ps
`default_nettype none

module dcache_miss_ctrl #(
    parameter int STORE_CNT_W = 2
) (
    input  wire logic                                clk_i,
    input  wire logic                                rst_n_i,
    // load miss
    input  wire logic                                ld_valid_i,
    input  wire logic [dcache_miss_pkg::ADDR_W-1:0]  ld_addr_i,
    input  wire logic [dcache_miss_pkg::L1_WAYS-1:0] way_valid_i,
    input  wire logic [dcache_miss_pkg::L1_WAYS-1:0][dcache_miss_pkg::TAG_W-1:0] way_tag_i,
    input  wire logic [dcache_miss_pkg::L1_WAYS-1:0] lru_onehot_i,
    output logic                                     ld_ready_o,
    output logic                                     ld_refill_done_o,
    // store
    input  wire logic                                st_valid_i,
    input  wire logic [dcache_miss_pkg::ADDR_W-1:0]  st_addr_i,
    input  wire logic [dcache_miss_pkg::DATA_W-1:0]  st_wdata_i,
    input  wire logic [dcache_miss_pkg::STRB_W-1:0]  st_strb_i,
    output logic                                     st_ready_o,
    output logic                                     st_ack_o,
    // L2
    output logic                                     l2_rd_en_o,
    output logic                                     l2_wr_en_o,
    output logic [dcache_miss_pkg::ADDR_W-1:0]       l2_addr_o,
    output logic [dcache_miss_pkg::DATA_W-1:0]       l2_wdata_o,
    output logic [dcache_miss_pkg::STRB_W-1:0]       l2_wstrb_o,
    input  wire logic                                l2_resp_i,
    // victim cache and tag array
    output logic                                     vc_wr_en_o,
    output logic [dcache_miss_pkg::VC_TAG_W-1:0]     vc_tag_o,
    output logic                                     refill_wr_en_o,
    output logic [dcache_miss_pkg::L1_WAYS-1:0]      refill_way_o,
    output logic [dcache_miss_pkg::ENTRY_SEL-1:0]    refill_entry_o
);

    logic store_issue;
    logic store_retire;
    logic credits_zero;
    logic credits_full;

    refill_if rif ();

    refill_fsm i_refill_fsm (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .ld_valid_i       (ld_valid_i),
        .credits_zero_i   (credits_zero),
        .ld_ready_o       (ld_ready_o),
        .vc_wr_en_o       (vc_wr_en_o),
        .refill_wr_en_o   (refill_wr_en_o),
        .ld_refill_done_o (ld_refill_done_o),
        .rif              (rif.fsm)
    );

    store_credit_counter #(
        .STORE_CNT_W (STORE_CNT_W)
    ) i_store_credit_counter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .store_issue_i  (store_issue),
        .store_retire_i (store_retire),
        .credits_zero_o (credits_zero),
        .credits_full_o (credits_full)
    );

    victim_record i_victim_record (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ld_addr_i      (ld_addr_i),
        .way_valid_i    (way_valid_i),
        .way_tag_i      (way_tag_i),
        .lru_onehot_i   (lru_onehot_i),
        .vc_tag_o       (vc_tag_o),
        .refill_way_o   (refill_way_o),
        .refill_entry_o (refill_entry_o),
        .rif            (rif.rec)
    );

    l2_port_mux #(
        .STORE_CNT_W (STORE_CNT_W)
    ) i_l2_port_mux (
        .st_addr_i      (st_addr_i),
        .st_wdata_i     (st_wdata_i),
        .st_strb_i      (st_strb_i),
        .st_valid_i     (st_valid_i),
        .l2_resp_i      (l2_resp_i),
        .credits_zero_i (credits_zero),
        .credits_full_i (credits_full),
        .st_ready_o     (st_ready_o),
        .st_ack_o       (st_ack_o),
        .store_issue_o  (store_issue),
        .store_retire_o (store_retire),
        .l2_rd_en_o     (l2_rd_en_o),
        .l2_wr_en_o     (l2_wr_en_o),
        .l2_addr_o      (l2_addr_o),
        .l2_wdata_o     (l2_wdata_o),
        .l2_wstrb_o     (l2_wstrb_o),
        .rif            (rif.port)
    );

endmodule

`default_nettype wire

// File: dcache_miss_assertions.sv
/*
 * Protocol checks for the miss controller.
 * Bound to the top level: L2 port exclusivity, load readiness
 * against the refill state and victim write followed by the fill.
 */

`timescale 1ns/10ps
`default_nettype none

module dcache_miss_assertions (
    input wire logic       clk_i,
    input wire logic       rst_n_i,
    input wire logic       ld_valid_i,
    input wire logic       l2_rd_en_i,
    input wire logic       l2_wr_en_i,
    input wire logic       ld_ready_i,
    input wire logic       vc_wr_en_i,
    input wire logic       refill_wr_en_i,
    input wire logic [2:0] state_i
);

    // failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // one request port, read and write never share a cycle
    a_port_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(l2_rd_en_i && l2_wr_en_i)
    ) else begin
        $error("l2_rd_en_o and l2_wr_en_o high in the same cycle");
        fail_count++;
    end

    // ready only in IDLE, and gone once a load has been taken
    a_ready_in_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ld_ready_i |-> (state_i == dcache_miss_pkg::IDLE) && !$past(ld_valid_i && ld_ready_i)
    ) else begin
        $error("ld_ready_o high outside IDLE or right after a load was accepted");
        fail_count++;
    end

    // victim step hands over to the fill
    a_victim_then_fill: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) vc_wr_en_i |=> refill_wr_en_i
    ) else begin
        $error("vc_wr_en_o not followed by refill_wr_en_o");
        fail_count++;
    end

endmodule

bind dcache_miss_ctrl dcache_miss_assertions i_assertions (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ld_valid_i     (ld_valid_i),
    .l2_rd_en_i     (l2_rd_en_o),
    .l2_wr_en_i     (l2_wr_en_o),
    .ld_ready_i     (ld_ready_o),
    .vc_wr_en_i     (vc_wr_en_o),
    .refill_wr_en_i (refill_wr_en_o),
    .state_i        (i_refill_fsm.state_q)
);

`default_nettype wire

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset.
 * 100 ns clock, active-low reset held for three rising edges.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // released on the third rising edge, after the DUT has sampled it low
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_dcache_miss_ctrl.sv
/*
 * Testbench for the L1 data cache miss controller.
 * Random loads and stores over a few lines, an in-order L2
 * responder and a cycle model of the refill and store counter.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_dcache_miss_ctrl;

    localparam int ADDR_W    = dcache_miss_pkg::ADDR_W;
    localparam int TAG_W     = dcache_miss_pkg::TAG_W;
    localparam int LINE_W    = dcache_miss_pkg::LINE_W;
    localparam int ENTRY_SEL = dcache_miss_pkg::ENTRY_SEL;
    localparam int WAYS      = dcache_miss_pkg::L1_WAYS;
    localparam int OFF_W     = ADDR_W - LINE_W;
    localparam int CNT_W     = 2;
    localparam int MAX_CNT   = (1 << CNT_W) - 1;
    localparam int NUM_OPS   = 400;
    localparam int TIMEOUT_CYCLES = 20 * NUM_OPS;

    logic clk;
    logic rst_n;

    logic                            ld_valid_i;
    logic [ADDR_W-1:0]               ld_addr_i;
    logic [WAYS-1:0]                 way_valid_i;
    logic [WAYS-1:0][TAG_W-1:0]      way_tag_i;
    logic [WAYS-1:0]                 lru_onehot_i;
    logic                            st_valid_i;
    logic [ADDR_W-1:0]               st_addr_i;
    logic [dcache_miss_pkg::DATA_W-1:0] st_wdata_i;
    logic [dcache_miss_pkg::STRB_W-1:0] st_strb_i;
    logic                            l2_resp_i;

    logic                            ld_ready_o;
    logic                            ld_refill_done_o;
    logic                            st_ready_o;
    logic                            st_ack_o;
    logic                            l2_rd_en_o;
    logic                            l2_wr_en_o;
    logic [ADDR_W-1:0]               l2_addr_o;
    logic [dcache_miss_pkg::DATA_W-1:0] l2_wdata_o;
    logic [dcache_miss_pkg::STRB_W-1:0] l2_wstrb_o;
    logic                            vc_wr_en_o;
    logic [dcache_miss_pkg::VC_TAG_W-1:0] vc_tag_o;
    logic                            refill_wr_en_o;
    logic [WAYS-1:0]                 refill_way_o;
    logic [ENTRY_SEL-1:0]            refill_entry_o;

    // reference model
    dcache_miss_pkg::refill_state_e m_state;
    int                         m_cnt;
    logic [LINE_W-1:0]          cap_line;
    logic [ENTRY_SEL-1:0]       cap_entry;
    logic [WAYS-1:0]            cap_valid;
    logic [WAYS-1:0]            cap_lru;
    logic [WAYS-1:0][TAG_W-1:0] cap_tags;
    logic                       rd_pushed;
    logic                       st_acc;

    // L2 responder, due cycle of each pending request in issue order
    int   resp_due[$];
    logic next_resp;

    int seed;
    int cycle;
    int ops_done;
    int stores_seen;
    int acks_seen;
    int timeout_cycles;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dcache_miss_ctrl #(
        .STORE_CNT_W (CNT_W)
    ) i_dut (
        .clk_i (clk), .rst_n_i (rst_n),
        .ld_valid_i (ld_valid_i), .ld_addr_i (ld_addr_i), .way_valid_i (way_valid_i),
        .way_tag_i (way_tag_i), .lru_onehot_i (lru_onehot_i),
        .ld_ready_o (ld_ready_o), .ld_refill_done_o (ld_refill_done_o),
        .st_valid_i (st_valid_i), .st_addr_i (st_addr_i), .st_wdata_i (st_wdata_i),
        .st_strb_i (st_strb_i), .st_ready_o (st_ready_o), .st_ack_o (st_ack_o),
        .l2_rd_en_o (l2_rd_en_o), .l2_wr_en_o (l2_wr_en_o), .l2_addr_o (l2_addr_o),
        .l2_wdata_o (l2_wdata_o), .l2_wstrb_o (l2_wstrb_o), .l2_resp_i (l2_resp_i),
        .vc_wr_en_o (vc_wr_en_o), .vc_tag_o (vc_tag_o), .refill_wr_en_o (refill_wr_en_o),
        .refill_way_o (refill_way_o), .refill_entry_o (refill_entry_o)
    );

    // ******************************************************************
    // error reporting
    // ******************************************************************
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // ******************************************************************
    // stimulus
    // ******************************************************************
    // four tags on two entries, so loads and stores often share a line
    function automatic logic [ADDR_W-1:0] pick_addr();
        logic [31:0]          r;
        logic [TAG_W-1:0]     tag;
        logic [ENTRY_SEL-1:0] entry;
        r     = $random(seed);
        tag   = TAG_W'(32'h2a0 + r[1:0]);
        entry = ENTRY_SEL'(32'h11 + r[2]);
        return {tag, entry, r[OFF_W+2:3]};
    endfunction

    task automatic drive_inputs();
        logic [31:0]                r;
        logic                       more;
        logic [WAYS-1:0][TAG_W-1:0] tags;
        more = (ops_done < NUM_OPS);
        r    = $random(seed);
        for (int w = 0; w < WAYS; w++) begin
            tags[w] = TAG_W'($random(seed));
        end
        ld_valid_i   <= more && (r[1:0] == 2'b00);
        st_valid_i   <= more && r[2];
        ld_addr_i    <= pick_addr();
        st_addr_i    <= pick_addr();
        st_wdata_i   <= $random(seed);
        st_strb_i    <= r[6:3];
        way_valid_i  <= r[7] ? {WAYS{1'b1}} : WAYS'(r[9:8]);
        way_tag_i    <= tags;
        lru_onehot_i <= WAYS'(1) << (r[12:11] % WAYS);
        l2_resp_i    <= next_resp;
    endtask

    // in-order L2, each request answered 1 to 6 cycles later
    task automatic push_request();
        logic [31:0] r;
        int          due;
        r   = $random(seed);
        due = cycle + 1 + (r[7:0] % 6);
        if (resp_due.size() > 0 && due <= resp_due[$]) begin
            due = resp_due[$] + 1;
        end
        resp_due.push_back(due);
    endtask

    // ******************************************************************
    // checks and model step
    // ******************************************************************
    task automatic check_outputs(output logic acc);
        logic             busy;
        logic             exp_ready;
        logic             exp_vc;
        logic [TAG_W-1:0] lru_tag;
        busy      = (m_state != dcache_miss_pkg::IDLE);
        exp_ready = !((busy && st_addr_i[ADDR_W-1:OFF_W] == cap_line)
                      || m_state == dcache_miss_pkg::FETCH || m_cnt == MAX_CNT);
        acc       = st_valid_i && exp_ready;
        exp_vc    = (m_state == dcache_miss_pkg::VICTIM) && (&cap_valid);
        lru_tag   = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (cap_lru[w]) begin
                lru_tag = cap_tags[w];
            end
        end
        check_value("ld_ready_o", ld_ready_o, !busy);
        check_value("st_ready_o", st_ready_o, exp_ready);
        check_value("l2_wr_en_o", l2_wr_en_o, acc);
        check_value("l2_rd_en_o", l2_rd_en_o, m_state == dcache_miss_pkg::FETCH);
        check_value("st_ack_o", st_ack_o, l2_resp_i && m_cnt != 0);
        check_value("vc_wr_en_o", vc_wr_en_o, exp_vc);
        check_value("refill_wr_en_o", refill_wr_en_o, m_state == dcache_miss_pkg::FILL);
        check_value("ld_refill_done_o", ld_refill_done_o, m_state == dcache_miss_pkg::FILL);
        if (acc) begin
            check_value("l2_addr_o", l2_addr_o, st_addr_i);
            check_value("l2_wdata_o", l2_wdata_o, st_wdata_i);
            check_value("l2_wstrb_o", l2_wstrb_o, st_strb_i);
        end
        if (m_state == dcache_miss_pkg::FETCH) begin
            check_value("l2_addr_o", l2_addr_o, {cap_line, {OFF_W{1'b0}}});
        end
        if (exp_vc) begin
            check_value("vc_tag_o", vc_tag_o, {lru_tag, cap_entry});
        end
        if (m_state == dcache_miss_pkg::FILL) begin
            check_value("refill_way_o", refill_way_o, cap_lru);
            check_value("refill_entry_o", refill_entry_o, cap_entry);
        end
    endtask

    task automatic step_model(input logic acc);
        logic ack;
        logic rd_done;
        ack     = l2_resp_i && (m_cnt != 0);
        rd_done = l2_resp_i && (m_cnt == 0) && (m_state == dcache_miss_pkg::FETCH);
        if (acc) stores_seen++;
        if (st_ack_o) acks_seen++;
        // every store ahead of the read has been acknowledged
        if (rd_done) begin
            check_value("st_ack_o count", acks_seen, stores_seen);
        end
        if (acc) begin
            ops_done++;
            push_request();
        end
        if (m_state == dcache_miss_pkg::FETCH && !rd_pushed) begin
            push_request();
            rd_pushed = 1'b1;
        end
        unique case (m_state)
            dcache_miss_pkg::IDLE: begin
                if (ld_valid_i) begin
                    cap_line  = ld_addr_i[ADDR_W-1:OFF_W];
                    cap_entry = ld_addr_i[OFF_W+ENTRY_SEL-1:OFF_W];
                    cap_valid = way_valid_i;
                    cap_lru   = lru_onehot_i;
                    cap_tags  = way_tag_i;
                    ops_done++;
                    m_state   = dcache_miss_pkg::DRAIN;
                end
            end
            dcache_miss_pkg::DRAIN: begin
                if (m_cnt == 0) m_state = dcache_miss_pkg::FETCH;
            end
            dcache_miss_pkg::FETCH: begin
                if (rd_done) begin
                    rd_pushed = 1'b0;
                    m_state   = dcache_miss_pkg::VICTIM;
                end
            end
            dcache_miss_pkg::VICTIM: m_state = dcache_miss_pkg::FILL;
            default: m_state = dcache_miss_pkg::IDLE;
        endcase
        m_cnt = m_cnt + (acc ? 1 : 0) - (ack ? 1 : 0);
    endtask

    // ******************************************************************
    // main sequence
    // ******************************************************************
    initial begin
        seed = 4;
        ld_valid_i = 1'b0;
        ld_addr_i = '0;
        way_valid_i = '0;
        way_tag_i = '0;
        lru_onehot_i = '0;
        st_valid_i = 1'b0;
        st_addr_i = '0;
        st_wdata_i = '0;
        st_strb_i = '0;
        l2_resp_i = 1'b0;
        m_state = dcache_miss_pkg::IDLE;
        m_cnt = 0;
        cap_line = '0;
        cap_entry = '0;
        cap_valid = '0;
        cap_lru = '0;
        cap_tags = '0;
        rd_pushed = 1'b0;
        next_resp = 1'b0;
        cycle = 0;
        ops_done = 0;
        stores_seen = 0;
        acks_seen = 0;

        // first checked cycle sees the post-reset outputs with idle inputs
        wait (rst_n === 1'b1);
        while (!(ops_done >= NUM_OPS && m_state == dcache_miss_pkg::IDLE
                 && m_cnt == 0 && resp_due.size() == 0)) begin
            @(negedge clk);
            cycle++;
            check_outputs(st_acc);
            step_model(st_acc);
            next_resp = 1'b0;
            if (resp_due.size() > 0 && resp_due[0] <= cycle + 1) begin
                next_resp = 1'b1;
                resp_due.delete(0);
            end
            @(posedge clk);
            drive_inputs();
        end

        if (i_dut.i_assertions.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "bound assertions reported %0d failures",
                   i_dut.i_assertions.fail_count);
        end
    end

    // watchdog
    initial begin
        timeout_cycles = 0;
    end

    always @(posedge clk) begin
        timeout_cycles++;
        if (timeout_cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by the watchdog");
        end
    end

endmodule

`default_nettype wire

// File: dcache_miss_ctrl.f
dcache_miss_pkg.sv
refill_if.sv
refill_fsm.sv
store_credit_counter.sv
victim_record.sv
l2_port_mux.sv
dcache_miss_ctrl.sv
dcache_miss_assertions.sv
tb_clock_gen.sv
tb_dcache_miss_ctrl.sv

// File: Bender.yml
package:
  name: dcache_miss_ctrl

sources:
  - dcache_miss_pkg.sv
  - refill_if.sv
  - refill_fsm.sv
  - store_credit_counter.sv
  - victim_record.sv
  - l2_port_mux.sv
  - dcache_miss_ctrl.sv
  - target: simulation
    files:
      - dcache_miss_assertions.sv
      - tb_clock_gen.sv
      - tb_dcache_miss_ctrl.sv
